// ==== src/rv_isa_pkg.sv ====
// RV64I instruction-set types and encodings shared by the decode and datapath logic
package rv_isa_pkg;

  // data and address word
  typedef logic [63:0] word_t;

  // one 32-bit instruction
  typedef logic [31:0] inst_t;

  // register file index
  typedef logic [4:0] reg_idx_t;

  // major opcodes
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;

  // funct7 for SUB, all other R-type ops use zero
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // full halt encoding
  localparam inst_t INST_EBREAK = 32'h0010_0073;

  // execute stage control
  typedef enum logic {
    RUN,
    HALT
  } exe_state_t;

endpackage

// ==== src/core_cfg_pkg.sv ====
// core configuration constants for fetch start address, buffering and bus codes
package core_cfg_pkg;

  // first fetch address after reset
  localparam rv_isa_pkg::word_t RESET_PC = 64'h0;

  // entries in the fetch to execute buffer
  localparam int BUF_DEPTH = 2;

  // if_size code for a 4-byte read
  localparam logic [1:0] BUS_SIZE_WORD = 2'b10;

  // good bus response
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== src/stage_if.sv ====
// req/ack link that moves one instruction and its pc from one stage to the next
`timescale 1ns/1ps

interface stage_if;

  logic               req;
  logic               ack;
  rv_isa_pkg::word_t  pc;
  rv_isa_pkg::inst_t  inst;

  // producer side
  modport src (
    output req,
    output pc,
    output inst,
    input  ack
  );

  // consumer side
  modport dst (
    input  req,
    input  pc,
    input  inst,
    output ack
  );

endinterface

// ==== src/if_stage.sv ====
// fetch stage issuing instruction bus reads and presenting each instruction downstream
`timescale 1ns/1ps

module if_stage (
  input  logic               clk,
  input  logic               rst_i,
  output logic               if_valid_o,
  output rv_isa_pkg::word_t  if_addr_o,
  output logic [1:0]         if_size_o,
  input  logic               if_ready_i,
  input  rv_isa_pkg::word_t  if_data_read_i,
  input  logic [1:0]         if_resp_i,
  input  logic               flush_i,
  input  rv_isa_pkg::word_t  flush_pc_i,
  output logic               fault_o,
  stage_if.src               fetch_q
);

  rv_isa_pkg::word_t pc_q;
  rv_isa_pkg::word_t addr_q;
  logic              busy_q;
  logic              discard_q;
  logic              have_q;
  logic              fault_q;
  rv_isa_pkg::inst_t inst_q;
  rv_isa_pkg::word_t inst_pc_q;

  logic              beat_done;
  logic              drop;
  logic              beat_keep;
  logic              issue;
  rv_isa_pkg::inst_t inst_half;

  assign beat_done = busy_q && if_ready_i;
  // data of a beat that straddles a redirect is stale
  assign drop      = discard_q || flush_i;
  assign beat_keep = beat_done && !drop && (if_resp_i == core_cfg_pkg::RESP_OKAY);
  assign issue     = !busy_q && !fault_q && (!have_q || flush_i);

  // doubleword bus, pick the 32-bit half by address bit 2
  assign inst_half = if_addr_o[2] ? if_data_read_i[63:32] : if_data_read_i[31:0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q      <= core_cfg_pkg::RESET_PC;
      addr_q    <= core_cfg_pkg::RESET_PC;
      busy_q    <= 1'b0;
      discard_q <= 1'b0;
      have_q    <= 1'b0;
      fault_q   <= 1'b0;
    end else begin
      if (flush_i) begin
        pc_q <= flush_pc_i;
      end else if (beat_keep) begin
        pc_q <= addr_q + 64'd4;
      end

      if (issue) begin
        busy_q <= 1'b1;
        addr_q <= flush_i ? flush_pc_i : pc_q;
      end else if (beat_done) begin
        busy_q <= 1'b0;
      end

      if (beat_done) begin
        discard_q <= 1'b0;
      end else if (flush_i && busy_q) begin
        discard_q <= 1'b1;
      end

      if (flush_i) begin
        have_q <= 1'b0;
      end else if (beat_keep) begin
        have_q <= 1'b1;
      end else if (fetch_q.req && fetch_q.ack) begin
        have_q <= 1'b0;
      end

      // sticky until reset
      if (beat_done && !drop && (if_resp_i != core_cfg_pkg::RESP_OKAY)) begin
        fault_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_keep) begin
      inst_q    <= inst_half;
      inst_pc_q <= addr_q;
    end
  end

  assign if_valid_o   = busy_q;
  assign if_addr_o    = addr_q;
  assign if_size_o    = core_cfg_pkg::BUS_SIZE_WORD;
  assign fault_o      = fault_q;

  assign fetch_q.req  = have_q;
  assign fetch_q.pc   = inst_pc_q;
  assign fetch_q.inst = inst_q;

endmodule

// ==== src/inst_buffer.sv ====
// small FIFO of fetched instructions between fetch and execute, emptied on a flush
`timescale 1ns/1ps

module inst_buffer (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  flush_i,
  stage_if.dst  fetch_q,
  stage_if.src  exe_q
);

  rv_isa_pkg::word_t pc_mem   [core_cfg_pkg::BUF_DEPTH];
  rv_isa_pkg::inst_t inst_mem [core_cfg_pkg::BUF_DEPTH];

  logic [$clog2(core_cfg_pkg::BUF_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(core_cfg_pkg::BUF_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(core_cfg_pkg::BUF_DEPTH+1)-1:0] count_q;

  logic push;
  logic pop;

  assign fetch_q.ack = (count_q < core_cfg_pkg::BUF_DEPTH);
  assign exe_q.req   = (count_q != '0);

  // entries arriving during a flush are stale
  assign push = fetch_q.req && fetch_q.ack && !flush_i;
  assign pop  = exe_q.req && exe_q.ack;

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == core_cfg_pkg::BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == core_cfg_pkg::BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr_q]   <= fetch_q.pc;
      inst_mem[wr_ptr_q] <= fetch_q.inst;
    end
  end

  // oldest entry
  assign exe_q.pc   = pc_mem[rd_ptr_q];
  assign exe_q.inst = inst_mem[rd_ptr_q];

endmodule

// ==== src/regfile.sv ====
// integer register file with two combinational reads and one synchronous write
`timescale 1ns/1ps

module regfile (
  input  logic                  clk,
  input  logic                  rst_i,
  input  rv_isa_pkg::reg_idx_t  rs1_i,
  input  rv_isa_pkg::reg_idx_t  rs2_i,
  output rv_isa_pkg::word_t     rs1_data_o,
  output rv_isa_pkg::word_t     rs2_data_o,
  input  rv_isa_pkg::reg_idx_t  rd_i,
  input  logic                  rd_wen_i,
  input  rv_isa_pkg::word_t     rd_wdata_i
);

  rv_isa_pkg::word_t regs_q [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rd_wen_i && (rd_i != '0)) begin
      regs_q[rd_i] <= rd_wdata_i;
    end
  end

  // x0 hardwired
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// ==== src/exe_stage.sv ====
// execute stage that decodes, computes, writes back and reports each retired instruction
`timescale 1ns/1ps

module exe_stage (
  input  logic                  clk,
  input  logic                  rst_i,
  stage_if.dst                  exe_q,
  output logic                  flush_o,
  output rv_isa_pkg::word_t     flush_pc_o,
  output logic                  halted_o,
  output logic                  cmt_valid_o,
  output rv_isa_pkg::word_t     cmt_pc_o,
  output rv_isa_pkg::inst_t     cmt_inst_o,
  output logic                  cmt_rd_wen_o,
  output rv_isa_pkg::reg_idx_t  cmt_rd_o,
  output rv_isa_pkg::word_t     cmt_rd_wdata_o
);

  rv_isa_pkg::exe_state_t state_q;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_isa_pkg::reg_idx_t  rs1;
  rv_isa_pkg::reg_idx_t  rs2;
  rv_isa_pkg::reg_idx_t  rd;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     imm_j;
  rv_isa_pkg::word_t     imm_b;
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;

  logic                  accept;
  logic                  wen;
  rv_isa_pkg::word_t     wdata;
  logic                  taken;
  rv_isa_pkg::word_t     target;
  logic                  halt_req;

  assign opcode = exe_q.inst[6:0];
  assign funct3 = exe_q.inst[14:12];
  assign funct7 = exe_q.inst[31:25];
  assign rs1    = exe_q.inst[19:15];
  assign rs2    = exe_q.inst[24:20];
  assign rd     = exe_q.inst[11:7];

  assign imm_i = {{52{exe_q.inst[31]}}, exe_q.inst[31:20]};
  assign imm_u = {{32{exe_q.inst[31]}}, exe_q.inst[31:12], 12'b0};
  assign imm_j = {{43{exe_q.inst[31]}}, exe_q.inst[31], exe_q.inst[19:12],
                  exe_q.inst[20], exe_q.inst[30:21], 1'b0};
  assign imm_b = {{51{exe_q.inst[31]}}, exe_q.inst[31], exe_q.inst[7],
                  exe_q.inst[30:25], exe_q.inst[11:8], 1'b0};

  assign exe_q.ack = (state_q == rv_isa_pkg::RUN);
  assign accept    = exe_q.req && exe_q.ack;

  regfile u_regfile (
    .clk        (clk          ),
    .rst_i      (rst_i        ),
    .rs1_i      (rs1          ),
    .rs2_i      (rs2          ),
    .rs1_data_o (rs1_data     ),
    .rs2_data_o (rs2_data     ),
    .rd_i       (rd           ),
    .rd_wen_i   (accept && wen),
    .rd_wdata_i (wdata        )
  );

  always_comb begin
    wen      = 1'b0;
    wdata    = '0;
    taken    = 1'b0;
    target   = exe_q.pc + imm_b;
    halt_req = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        if (funct3 == rv_isa_pkg::F3_ADD) begin
          wen   = 1'b1;
          wdata = rs1_data + imm_i;
        end
      end
      rv_isa_pkg::OP_REG: begin
        wen = 1'b1;
        if (funct3 == rv_isa_pkg::F3_ADD && funct7 == rv_isa_pkg::F7_SUB) begin
          wdata = rs1_data - rs2_data;
        end else if (funct7 != 7'b0) begin
          wen = 1'b0;
        end else begin
          case (funct3)
            rv_isa_pkg::F3_ADD: wdata = rs1_data + rs2_data;
            rv_isa_pkg::F3_XOR: wdata = rs1_data ^ rs2_data;
            rv_isa_pkg::F3_OR:  wdata = rs1_data | rs2_data;
            rv_isa_pkg::F3_AND: wdata = rs1_data & rs2_data;
            default:            wen   = 1'b0;
          endcase
        end
      end
      rv_isa_pkg::OP_LUI: begin
        wen   = 1'b1;
        wdata = imm_u;
      end
      rv_isa_pkg::OP_JAL: begin
        wen    = 1'b1;
        wdata  = exe_q.pc + 64'd4;
        taken  = 1'b1;
        target = exe_q.pc + imm_j;
      end
      rv_isa_pkg::OP_BRANCH: begin
        if (funct3 == rv_isa_pkg::F3_BEQ) begin
          taken = (rs1_data == rs2_data);
        end
      end
      rv_isa_pkg::OP_SYSTEM: begin
        halt_req = (exe_q.inst == rv_isa_pkg::INST_EBREAK);
      end
      // anything else retires as a no-op
      default: ;
    endcase
  end

  // no prediction, every taken control transfer redirects fetch
  assign flush_o    = accept && taken;
  assign flush_pc_o = target;
  assign halted_o   = (state_q == rv_isa_pkg::HALT);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= rv_isa_pkg::RUN;
      cmt_valid_o <= 1'b0;
    end else begin
      cmt_valid_o <= accept;
      if (accept && halt_req) begin
        state_q <= rv_isa_pkg::HALT;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmt_pc_o       <= exe_q.pc;
      cmt_inst_o     <= exe_q.inst;
      cmt_rd_wen_o   <= wen;
      cmt_rd_o       <= rd;
      cmt_rd_wdata_o <= wdata;
    end
  end

endmodule

// ==== src/cpu.sv ====
// top level of the RV64I core joining fetch, buffer and execute to the bus and commit ports
`timescale 1ns/1ps

module cpu (
  input  logic                  clk,
  input  logic                  rst_i,
  output logic                  if_valid_o,
  output rv_isa_pkg::word_t     if_addr_o,
  output logic [1:0]            if_size_o,
  input  logic                  if_ready_i,
  input  rv_isa_pkg::word_t     if_data_read_i,
  input  logic [1:0]            if_resp_i,
  output logic                  cmt_valid_o,
  output rv_isa_pkg::word_t     cmt_pc_o,
  output rv_isa_pkg::inst_t     cmt_inst_o,
  output logic                  cmt_rd_wen_o,
  output rv_isa_pkg::reg_idx_t  cmt_rd_o,
  output rv_isa_pkg::word_t     cmt_rd_wdata_o,
  output logic                  halted_o,
  output logic                  fault_o
);

  // redirect from execute
  logic              flush;
  rv_isa_pkg::word_t flush_pc;

  stage_if fetch_q ();
  stage_if exe_q ();

  if_stage u_if_stage (
    .clk            (clk           ),
    .rst_i          (rst_i         ),
    .if_valid_o     (if_valid_o    ),
    .if_addr_o      (if_addr_o     ),
    .if_size_o      (if_size_o     ),
    .if_ready_i     (if_ready_i    ),
    .if_data_read_i (if_data_read_i),
    .if_resp_i      (if_resp_i     ),
    .flush_i        (flush         ),
    .flush_pc_i     (flush_pc      ),
    .fault_o        (fault_o       ),
    .fetch_q        (fetch_q       )
  );

  inst_buffer u_inst_buffer (
    .clk            (clk           ),
    .rst_i          (rst_i         ),
    .flush_i        (flush         ),
    .fetch_q        (fetch_q       ),
    .exe_q          (exe_q         )
  );

  exe_stage u_exe_stage (
    .clk            (clk           ),
    .rst_i          (rst_i         ),
    .exe_q          (exe_q         ),
    .flush_o        (flush         ),
    .flush_pc_o     (flush_pc      ),
    .halted_o       (halted_o      ),
    .cmt_valid_o    (cmt_valid_o   ),
    .cmt_pc_o       (cmt_pc_o      ),
    .cmt_inst_o     (cmt_inst_o    ),
    .cmt_rd_wen_o   (cmt_rd_wen_o  ),
    .cmt_rd_o       (cmt_rd_o      ),
    .cmt_rd_wdata_o (cmt_rd_wdata_o)
  );

endmodule

// ==== sim/tb_program.svh ====
// test program, its bus image and a reference ISA model, included into the core testbench
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

  typedef enum {K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_LUI, K_JAL, K_BEQ, K_EBREAK} kind_e;

  // program as fields, one entry per word from RESET_PC
  kind_e  p_kind [$];
  int     p_rd   [$];
  int     p_rs1  [$];
  int     p_rs2  [$];
  longint p_imm  [$];

  // expected commit stream
  rv_isa_pkg::word_t exp_pc    [$];
  rv_isa_pkg::inst_t exp_inst  [$];
  logic              exp_wen   [$];
  int                exp_rd    [$];
  rv_isa_pkg::word_t exp_wdata [$];

  task automatic add_inst(input kind_e k, input int rd, input int rs1, input int rs2,
                          input longint imm);
    p_kind.push_back(k);
    p_rd.push_back(rd);
    p_rs1.push_back(rs1);
    p_rs2.push_back(rs2);
    p_imm.push_back(imm);
  endtask

  function automatic rv_isa_pkg::inst_t encode(input int n);
    logic [20:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    imm = 21'(p_imm[n]);
    rd  = 5'(p_rd[n]);
    rs1 = 5'(p_rs1[n]);
    rs2 = 5'(p_rs2[n]);
    case (p_kind[n])
      K_ADDI:  return {imm[11:0], rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_IMM};
      K_ADD:   return {7'b0, rs2, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_REG};
      K_SUB:   return {rv_isa_pkg::F7_SUB, rs2, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_REG};
      K_AND:   return {7'b0, rs2, rs1, rv_isa_pkg::F3_AND, rd, rv_isa_pkg::OP_REG};
      K_OR:    return {7'b0, rs2, rs1, rv_isa_pkg::F3_OR, rd, rv_isa_pkg::OP_REG};
      K_XOR:   return {7'b0, rs2, rs1, rv_isa_pkg::F3_XOR, rd, rv_isa_pkg::OP_REG};
      K_LUI:   return {imm[19:0], rd, rv_isa_pkg::OP_LUI};
      K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
      K_BEQ:   return {imm[12], imm[10:5], rs2, rs1, rv_isa_pkg::F3_BEQ, imm[4:1], imm[11],
                       rv_isa_pkg::OP_BRANCH};
      default: return rv_isa_pkg::INST_EBREAK;
    endcase
  endfunction

  // words past the program hold an ADDI to x15 whose immediate folds the whole address
  function automatic rv_isa_pkg::inst_t fetch_word(input rv_isa_pkg::word_t addr);
    logic [11:0] fold;
    fold = 12'(addr ^ (addr >> 12) ^ (addr >> 24) ^ (addr >> 36) ^ (addr >> 48) ^ (addr >> 60));
    if ((addr >> 2) < p_kind.size()) begin
      return encode(int'(addr >> 2));
    end
    return {fold, 5'd0, rv_isa_pkg::F3_ADD, 5'd15, rv_isa_pkg::OP_IMM};
  endfunction

  task automatic load_program();
    add_inst(K_ADDI, 1, 0, 0, 5);
    add_inst(K_ADDI, 2, 0, 0, -3);
    add_inst(K_ADD, 3, 1, 2, 0);
    add_inst(K_SUB, 4, 1, 2, 0);
    add_inst(K_AND, 5, 1, 2, 0);
    add_inst(K_OR, 6, 1, 2, 0);
    add_inst(K_XOR, 7, 1, 2, 0);
    add_inst(K_LUI, 8, 0, 0, 'h12345);
    // write x0, then read it back
    add_inst(K_ADDI, 0, 1, 0, 7);
    add_inst(K_ADD, 9, 0, 1, 0);
    // jal and taken beq each skip two words
    add_inst(K_JAL, 10, 0, 0, 12);
    add_inst(K_ADDI, 11, 0, 0, 1);
    add_inst(K_ADDI, 11, 0, 0, 2);
    add_inst(K_BEQ, 0, 1, 9, 12);
    add_inst(K_ADDI, 12, 0, 0, 1);
    add_inst(K_ADDI, 12, 0, 0, 2);
    // not taken, 5 vs -3
    add_inst(K_BEQ, 0, 1, 2, 8);
    add_inst(K_ADDI, 13, 0, 0, 9);
    add_inst(K_LUI, 14, 0, 0, -524288);
    add_inst(K_EBREAK, 0, 0, 0, 0);
  endtask

  // steps the program from RESET_PC until EBREAK
  task automatic build_golden();
    rv_isa_pkg::word_t regs [32];
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t next;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::word_t wd;
    logic              wen;
    logic              done;
    int                n;
    foreach (regs[r]) regs[r] = '0;
    pc   = core_cfg_pkg::RESET_PC;
    done = 1'b0;
    while (!done) begin
      n    = int'(pc >> 2);
      a    = regs[p_rs1[n]];
      b    = regs[p_rs2[n]];
      imm  = p_imm[n];
      wen  = 1'b1;
      wd   = '0;
      next = pc + 4;
      case (p_kind[n])
        K_ADDI: wd = a + imm;
        K_ADD:  wd = a + b;
        K_SUB:  wd = a - b;
        K_AND:  wd = a & b;
        K_OR:   wd = a | b;
        K_XOR:  wd = a ^ b;
        K_LUI:  wd = imm << 12;
        K_JAL: begin
          wd   = pc + 4;
          next = pc + imm;
        end
        K_BEQ: begin
          wen = 1'b0;
          if (a == b) next = pc + imm;
        end
        default: begin
          wen  = 1'b0;
          done = 1'b1;
        end
      endcase
      exp_pc.push_back(pc);
      exp_inst.push_back(encode(n));
      exp_wen.push_back(wen);
      exp_rd.push_back(p_rd[n]);
      exp_wdata.push_back(wd);
      if (wen && p_rd[n] != 0) regs[p_rd[n]] = wd;
      pc = next;
    end
  endtask

`endif

// ==== sim/tb_cpu.sv ====
// testbench for the RV64I core, checks every commit against a reference model and a bus fault
`timescale 1ns/1ps

module tb_cpu;

  `include "tb_program.svh"

  // fetch may still need three beats at the slowest latency after halt
  localparam int HALT_SETTLE = 20;

  logic                 clk = 1'b0;
  logic                 rst_i = 1'b1;
  logic                 if_ready_i = 1'b0;
  rv_isa_pkg::word_t    if_data_read_i = '0;
  logic [1:0]           if_resp_i = core_cfg_pkg::RESP_OKAY;
  logic                 if_valid_o;
  rv_isa_pkg::word_t    if_addr_o;
  logic [1:0]           if_size_o;
  logic                 cmt_valid_o;
  rv_isa_pkg::word_t    cmt_pc_o;
  rv_isa_pkg::inst_t    cmt_inst_o;
  logic                 cmt_rd_wen_o;
  rv_isa_pkg::reg_idx_t cmt_rd_o;
  rv_isa_pkg::word_t    cmt_rd_wdata_o;
  logic                 halted_o;
  logic                 fault_o;

  integer seed = 32'h2fc9;
  int     delay = 0;
  int     errors = 0;
  int     n_cmt = 0;
  logic   fault_mode = 1'b0;

  cpu DUT (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  // bus memory, 0 to 3 wait cycles per beat
  always @(negedge clk) begin
    if (rst_i || if_ready_i || !if_valid_o) begin
      if_ready_i = 1'b0;
      delay      = {$random(seed)} % 4;
    end else if (delay == 0) begin
      // every fetch is a 4-byte read
      check_val("bus size", 2'b10, if_size_o);
      if_ready_i     = 1'b1;
      if_data_read_i = {fetch_word({if_addr_o[63:3], 3'b100}),
                        fetch_word({if_addr_o[63:3], 3'b000})};
      if_resp_i      = fault_mode ? 2'b10 : core_cfg_pkg::RESP_OKAY;
    end else begin
      delay = delay - 1;
    end
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (16) @(negedge clk);
    assert (!if_valid_o && !cmt_valid_o && !halted_o && !fault_o) else begin
      errors++;
      $display("core outputs not idle at the end of reset");
    end
    rst_i = 1'b0;
  endtask

  // commit outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_i && cmt_valid_o) begin
      assert (!fault_mode && n_cmt < exp_pc.size()) else begin
        errors++;
        $display("unexpected commit at pc %h", cmt_pc_o);
      end
      if (!fault_mode && n_cmt < exp_pc.size()) begin
        check_val($sformatf("commit %0d pc", n_cmt), exp_pc[n_cmt], cmt_pc_o);
        check_val($sformatf("commit %0d inst", n_cmt), exp_inst[n_cmt], cmt_inst_o);
        check_val($sformatf("commit %0d rd_wen", n_cmt), exp_wen[n_cmt], cmt_rd_wen_o);
        if (exp_wen[n_cmt]) begin
          check_val($sformatf("commit %0d rd", n_cmt), exp_rd[n_cmt], cmt_rd_o);
          check_val($sformatf("commit %0d rd_wdata", n_cmt), exp_wdata[n_cmt], cmt_rd_wdata_o);
        end
      end
      n_cmt++;
    end
  end

  initial begin
    #1;
    repeat (40 * p_kind.size() + 200) @(posedge clk);
    $display("timeout after %0d cycles, the core never finished", 40 * p_kind.size() + 200);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    load_program();
    build_golden();
    apply_reset();
    // program run up to EBREAK
    wait (halted_o);
    repeat (HALT_SETTLE) @(negedge clk);
    repeat (20) begin
      assert (!if_valid_o && halted_o) else begin
        errors++;
        $display("fetch still active or halt dropped after EBREAK");
      end
      @(negedge clk);
    end
    assert (n_cmt == exp_pc.size()) else begin
      errors++;
      $display("committed %0d instructions, expected %0d", n_cmt, exp_pc.size());
    end
    // every beat now answers with an error response
    fault_mode = 1'b1;
    apply_reset();
    wait (fault_o);
    repeat (20) begin
      @(negedge clk);
      assert (fault_o && !if_valid_o) else begin
        errors++;
        $display("fault_o dropped or fetch went on after a bus error");
      end
    end
    $display("errors %0d, commits %0d", errors, n_cmt);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== cpu.f ====
+incdir+sim
src/rv_isa_pkg.sv
src/core_cfg_pkg.sv
src/stage_if.sv
src/if_stage.sv
src/inst_buffer.sv
src/regfile.sv
src/exe_stage.sv
src/cpu.sv
sim/tb_cpu.sv
